// File: design/cart_load_pkg.sv
// Shared definitions for the cartridge load control logic
//   Download port, cartridge info, RAM fill and cheat code structs
//   SD image and SD request structs
//   Copier header and map-mode header offsets
//   Download index codes, fill patterns and sector shift
package cart_load_pkg;

	//========================================================================
	// Types
	//========================================================================

	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_bus_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic [3:0]  ram_size;
		logic        pal;
	} cart_info_t;

	typedef struct packed {
		logic        we;
		logic [17:0] addr;
		logic [7:0]  wram_data;
		logic [7:0]  aram_data;
	} fill_port_t;

	// Flags in the top word, replace value in the bottom word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        mounted;
		logic        readonly;
		logic [63:0] size;
	} sd_image_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	//========================================================================
	// Constants
	//========================================================================

	// Copier header in front of the ROM image
	localparam logic [24:0] HDR_SKIP         = 25'h000200;

	// Size word of the internal header, RAM size word sits 2 bytes higher
	localparam logic [24:0] HDR_LOROM_BASE   = 25'h007FD6;
	localparam logic [24:0] HDR_HIROM_BASE   = 25'h00FFD6;
	localparam logic [24:0] HDR_EXHIROM_BASE = 25'h40FFD6;

	localparam logic [5:0]  IDX_CART         = 6'h01;
	localparam logic [5:0]  IDX_SPC          = 6'h04;

	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'hC;

	localparam int          SECTOR_SHIFT     = 9;

	// Power-on RAM patterns
	localparam logic [7:0]  FILL_PAT_66      = 8'h66;
	localparam logic [7:0]  FILL_PAT_99      = 8'h99;
	localparam logic [7:0]  FILL_PAT_00      = 8'h00;
	localparam logic [7:0]  FILL_PAT_55      = 8'h55;
	localparam logic [7:0]  FILL_PAT_FF      = 8'hFF;

endpackage

// File: design/download_decoder.sv
// Download stream decoder
//   Splits the host download into cartridge, audio program and cheat streams
//   Registered start and end strobes of a cartridge download
module download_decoder (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_load_pkg::dl_bus_t dl_i,
	output logic                   cart_active_o,
	output logic                   spc_active_o,
	output logic                   code_active_o,
	output logic                   cart_start_o,
	output logic                   cart_end_o
);

	logic cart_active;
	logic cart_q;
	logic start_q;
	logic end_q;

	// Only the low six index bits select the stream type
	assign cart_active = dl_i.active && (dl_i.index[5:0] == cart_load_pkg::IDX_CART);

	assign cart_active_o = cart_active;
	assign spc_active_o  = dl_i.active && (dl_i.index[5:0] == cart_load_pkg::IDX_SPC);
	// All ones marks a cheat file
	assign code_active_o = dl_i.active && (&dl_i.index);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q  <= 1'b0;
			start_q <= 1'b0;
			end_q   <= 1'b0;
		end else begin
			cart_q  <= cart_active;
			start_q <= cart_active & ~cart_q;
			end_q   <= ~cart_active & cart_q;
		end
	end

	assign cart_start_o = start_q;
	assign cart_end_o   = end_q;

endmodule

// File: design/rom_header_parser.sv
// ROM header parser
//   Map type, ROM and RAM size from cartridge download writes
//   Size masks and video region selection
module rom_header_parser (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  cart_load_pkg::dl_bus_t    dl_i,
	input  logic                      cart_active_i,
	input  logic [2:0]                header_mode_i,
	input  logic [1:0]                region_sel_i,
	output cart_load_pkg::cart_info_t info_o
);

	logic [3:0]  rom_size_q;
	logic [3:0]  ram_size_q;
	logic [7:0]  rom_type_q;
	logic        region_q;
	logic        pal_q;
	logic        hdr_wr;
	logic        fixed_map;
	logic [24:0] map_base;
	logic [24:0] size_addr;
	logic [24:0] ram_addr;

	assign hdr_wr = cart_active_i & dl_i.wr;

	// Header location for the forced map modes
	always_comb begin
		fixed_map = 1'b1;
		case (header_mode_i)
			3'd2:    map_base = cart_load_pkg::HDR_LOROM_BASE;
			3'd3:    map_base = cart_load_pkg::HDR_HIROM_BASE;
			3'd4:    map_base = cart_load_pkg::HDR_EXHIROM_BASE;
			default: begin
				map_base  = '0;
				fixed_map = 1'b0;
			end
		endcase
	end

	assign size_addr = map_base + cart_load_pkg::HDR_SKIP;
	assign ram_addr  = size_addr + 25'd2;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size_q <= cart_load_pkg::DEFAULT_ROM_SIZE;
			ram_size_q <= 4'd0;
			rom_type_q <= 8'd0;
			region_q   <= 1'b0;
			pal_q      <= 1'b0;
		end else begin
			if (hdr_wr) begin
				if (dl_i.addr == 25'd0) begin
					rom_size_q <= cart_load_pkg::DEFAULT_ROM_SIZE;
					ram_size_q <= 4'd0;
					// Auto mode, the loader puts both sizes in the low byte
					if (header_mode_i == 3'd0 && dl_i.data[7:0] != 8'd0) begin
						{ram_size_q, rom_size_q} <= dl_i.data[7:0];
					end
					case (header_mode_i)
						3'd1, 3'd2: rom_type_q <= 8'd0;
						3'd3:       rom_type_q <= 8'd1;
						3'd4:       rom_type_q <= 8'd2;
						default:    rom_type_q <= dl_i.data[15:8];
					endcase
				end
				if (dl_i.addr == 25'd2) begin
					region_q <= dl_i.data[8];
				end
				if (fixed_map && dl_i.addr == size_addr) begin
					rom_size_q <= dl_i.data[11:8];
				end
				if (fixed_map && dl_i.addr == ram_addr) begin
					ram_size_q <= dl_i.data[3:0];
				end
			end
			// Region is frozen while a cartridge streams in
			if (!cart_active_i) begin
				pal_q <= (region_sel_i == 2'd0) ? region_q : region_sel_i[1];
			end
		end
	end

	always_comb begin
		info_o.rom_type = rom_type_q;
		info_o.rom_mask = (24'd1024 << rom_size_q) - 24'd1;
		info_o.ram_mask = (ram_size_q != 4'd0) ? (24'd1024 << ram_size_q) - 24'd1 : 24'd0;
		info_o.ram_size = ram_size_q;
		info_o.pal      = pal_q;
	end

endmodule

// File: design/mem_clear_engine.sv
// Work RAM and audio RAM clear engine
//   Address sweep with a write every second cycle
//   Power-on pattern selection for each RAM
module mem_clear_engine #(
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      start_i,
	input  logic [1:0]                wram_mode_i,
	input  logic [1:0]                aram_mode_i,
	output logic                      clearing_o,
	output cart_load_pkg::fill_port_t fill_o
);

	logic                      clearing_q;
	logic                      wait_q;
	logic [FILL_ADDR_BITS-1:0] addr_q;
	logic                      clearing_d;
	logic                      wait_d;
	logic [FILL_ADDR_BITS-1:0] addr_d;
	logic [17:0]               addr_ext;
	logic                      we_q;
	logic [17:0]               fill_addr_q;
	logic [7:0]                wram_q;
	logic [7:0]                aram_q;

	function automatic logic [7:0] fill_pattern(input logic [1:0] mode, input logic [17:0] a);
		case (mode)
			2'd0:    fill_pattern = (a[8] ^ a[2]) ? cart_load_pkg::FILL_PAT_66
				: cart_load_pkg::FILL_PAT_99;
			2'd1:    fill_pattern = (a[9] ^ a[0]) ? cart_load_pkg::FILL_PAT_FF
				: cart_load_pkg::FILL_PAT_00;
			2'd2:    fill_pattern = cart_load_pkg::FILL_PAT_55;
			default: fill_pattern = cart_load_pkg::FILL_PAT_FF;
		endcase
	endfunction

	// Next state of the sweep, the fill port is registered from it
	always_comb begin
		clearing_d = clearing_q;
		wait_d     = wait_q;
		addr_d     = addr_q;
		if (start_i) begin
			clearing_d = 1'b1;
			wait_d     = 1'b0;
			addr_d     = '0;
		end else if (clearing_q) begin
			wait_d = ~wait_q;
			if (wait_q) begin
				addr_d = addr_q + 1'b1;
			end else if (&addr_q) begin
				clearing_d = 1'b0;
			end
		end else begin
			wait_d = 1'b0;
			addr_d = '0;
		end
	end

	// Bits above the sweep width read as zero
	assign addr_ext = 18'(addr_d);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing_q <= 1'b0;
			wait_q     <= 1'b0;
			addr_q     <= '0;
			we_q       <= 1'b0;
		end else begin
			clearing_q <= clearing_d;
			wait_q     <= wait_d;
			addr_q     <= addr_d;
			we_q       <= clearing_d & ~wait_d;
		end
	end

	always_ff @(posedge clk_sys) begin
		fill_addr_q <= addr_ext;
		wram_q      <= fill_pattern(wram_mode_i, addr_ext);
		aram_q      <= fill_pattern(aram_mode_i, addr_ext);
	end

	assign clearing_o = clearing_q;

	always_comb begin
		fill_o.we        = we_q;
		fill_o.addr      = fill_addr_q;
		fill_o.wram_data = wram_q;
		fill_o.aram_data = aram_q;
	end

endmodule

// File: design/cheat_code_loader.sv
// Cheat code loader
//   Places eight download words into one 128-bit code
//   Valid strobe on the last word
module cheat_code_loader (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  cart_load_pkg::dl_bus_t     dl_i,
	input  logic                       code_active_i,
	output cart_load_pkg::cheat_code_t code_o,
	output logic                       code_valid_o
);

	cart_load_pkg::cheat_code_t code_q;
	logic                       valid_q;
	logic                       code_wr;

	assign code_wr = code_active_i & dl_i.wr;

	// Low word of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_i.addr[3:0])
				4'd0:    code_q.flags[15:0]    <= dl_i.data;
				4'd2:    code_q.flags[31:16]   <= dl_i.data;
				4'd4:    code_q.address[15:0]  <= dl_i.data;
				4'd6:    code_q.address[31:16] <= dl_i.data;
				4'd8:    code_q.compare[15:0]  <= dl_i.data;
				4'd10:   code_q.compare[31:16] <= dl_i.data;
				4'd12:   code_q.replace[15:0]  <= dl_i.data;
				4'd14:   code_q.replace[31:16] <= dl_i.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= code_wr && (dl_i.addr[3:0] == 4'd14);
		end
	end

	assign code_o       = code_q;
	assign code_valid_o = valid_q;

endmodule

// File: design/backup_ram_sequencer.sv
// Backup RAM sequencer
//   Backup enable from the mounted save image
//   Sector by sector SD reads on load and writes on save
module backup_ram_sequencer (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     cart_active_i,
	input  logic                     cart_start_i,
	input  logic                     cart_end_i,
	input  logic [23:0]              ram_mask_i,
	input  cart_load_pkg::sd_image_t img_i,
	input  logic                     bk_load_i,
	input  logic                     bk_save_i,
	input  logic                     sd_ack_i,
	output cart_load_pkg::sd_req_t   sd_o,
	output logic                     bk_busy_o,
	output logic                     bk_loading_o
);

	logic        bk_ena_q;
	logic        busy_q;
	logic        loading_q;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        rd_q;
	logic        wr_q;
	logic [31:0] lba_q;
	logic [31:0] lba_end;
	logic        load_edge;
	logic        save_edge;
	logic        auto_load;
	logic        start_read;
	logic        start_any;
	logic        ack_rise;
	logic        ack_fall;

	// Last sector of the backup area
	assign lba_end = 32'(ram_mask_i >> cart_load_pkg::SECTOR_SHIFT);

	assign load_edge  = bk_load_i & ~load_q & bk_ena_q;
	assign save_edge  = bk_save_i & ~save_q & bk_ena_q;
	assign auto_load  = cart_end_i & (|img_i.size) & bk_ena_q;
	assign start_read = load_edge | auto_load;
	assign start_any  = start_read | save_edge;
	assign ack_rise   = sd_ack_i & ~ack_q;
	assign ack_fall   = ~sd_ack_i & ack_q;

	//========================================================================
	// Control
	//========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena_q  <= 1'b0;
			busy_q    <= 1'b0;
			loading_q <= 1'b0;
			load_q    <= 1'b0;
			save_q    <= 1'b0;
			ack_q     <= 1'b0;
			rd_q      <= 1'b0;
			wr_q      <= 1'b0;
		end else begin
			load_q <= bk_load_i;
			save_q <= bk_save_i;
			ack_q  <= sd_ack_i;

			if (cart_start_i) begin
				bk_ena_q <= 1'b0;
			end
			// Save image is mounted by the time the cartridge streams in
			if (cart_active_i && img_i.mounted && !img_i.readonly) begin
				bk_ena_q <= |ram_mask_i;
			end

			if (ack_rise) begin
				rd_q <= 1'b0;
				wr_q <= 1'b0;
			end

			if (!busy_q) begin
				if (start_any) begin
					busy_q    <= 1'b1;
					loading_q <= start_read;
					rd_q      <= start_read;
					wr_q      <= ~start_read;
				end
			end else if (ack_fall) begin
				if (lba_q >= lba_end) begin
					busy_q    <= 1'b0;
					loading_q <= 1'b0;
				end else begin
					rd_q <= loading_q;
					wr_q <= ~loading_q;
				end
			end
		end
	end

	// Sector address
	always_ff @(posedge clk_sys) begin
		if (!busy_q && start_any) begin
			lba_q <= 32'd0;
		end else if (busy_q && ack_fall && lba_q < lba_end) begin
			lba_q <= lba_q + 32'd1;
		end
	end

	always_comb begin
		sd_o.lba = lba_q;
		sd_o.rd  = rd_q;
		sd_o.wr  = wr_q;
	end

	assign bk_busy_o    = busy_q;
	assign bk_loading_o = loading_q;

endmodule

// File: design/cart_loader_top.sv
// Cartridge load control top level
//   Download decoder, header parser, RAM clear, cheat loader, backup RAM
//   Registered cartridge info and core reset request
module cart_loader_top #(
	parameter int FILL_ADDR_BITS = 18
) (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  cart_load_pkg::dl_bus_t     dl_i,
	input  logic [2:0]                 header_mode_i,
	input  logic [1:0]                 region_sel_i,
	input  logic [1:0]                 wram_mode_i,
	input  logic [1:0]                 aram_mode_i,
	input  cart_load_pkg::sd_image_t   img_i,
	input  logic                       bk_load_i,
	input  logic                       bk_save_i,
	input  logic                       sd_ack_i,
	output cart_load_pkg::cart_info_t  info_o,
	output logic                       clearing_o,
	output cart_load_pkg::fill_port_t  fill_o,
	output cart_load_pkg::cheat_code_t code_o,
	output logic                       code_valid_o,
	output cart_load_pkg::sd_req_t     sd_o,
	output logic                       bk_busy_o,
	output logic                       core_reset_o
);

	logic                      cart_active;
	logic                      spc_active;
	logic                      code_active;
	logic                      cart_start;
	logic                      cart_end;
	logic                      bk_loading;
	logic                      clearing;
	cart_load_pkg::cart_info_t info_w;
	cart_load_pkg::cart_info_t info_q;
	logic                      core_reset_q;

	download_decoder download_decoder_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_i          (dl_i),
		.cart_active_o (cart_active),
		.spc_active_o  (spc_active),
		.code_active_o (code_active),
		.cart_start_o  (cart_start),
		.cart_end_o    (cart_end)
	);

	rom_header_parser rom_header_parser_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_i          (dl_i),
		.cart_active_i (cart_active),
		.header_mode_i (header_mode_i),
		.region_sel_i  (region_sel_i),
		.info_o        (info_w)
	);

	mem_clear_engine #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) mem_clear_engine_i (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.start_i     (cart_start),
		.wram_mode_i (wram_mode_i),
		.aram_mode_i (aram_mode_i),
		.clearing_o  (clearing),
		.fill_o      (fill_o)
	);

	cheat_code_loader cheat_code_loader_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_i          (dl_i),
		.code_active_i (code_active),
		.code_o        (code_o),
		.code_valid_o  (code_valid_o)
	);

	backup_ram_sequencer backup_ram_sequencer_i (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_active_i (cart_active),
		.cart_start_i  (cart_start),
		.cart_end_i    (cart_end),
		.ram_mask_i    (info_w.ram_mask),
		.img_i         (img_i),
		.bk_load_i     (bk_load_i),
		.bk_save_i     (bk_save_i),
		.sd_ack_i      (sd_ack_i),
		.sd_o          (sd_o),
		.bk_busy_o     (bk_busy_o),
		.bk_loading_o  (bk_loading)
	);

	// Masks are combinational in the parser
	always_ff @(posedge clk_sys) begin
		info_q <= info_w;
	end

	// Core held in reset while memory contents are still changing
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			core_reset_q <= 1'b1;
		end else begin
			core_reset_q <= cart_active | spc_active | clearing | bk_loading;
		end
	end

	assign info_o       = info_q;
	assign clearing_o   = clearing;
	assign core_reset_o = core_reset_q;

endmodule

// File: tests/cart_loader_assertions.sv
// Bound checks on the cartridge loader outputs
//   Fill pattern, spacing and end of the clear, cheat valid pulse
//   SD handshake, outputs after reset, core reset during clear
module cart_loader_assertions (
	input logic                       clk_sys,
	input logic                       RESET,
	input logic [1:0]                 wram_mode_i,
	input logic [1:0]                 aram_mode_i,
	input logic                       sd_ack_i,
	input cart_load_pkg::cart_info_t  info_o,
	input logic                       clearing_o,
	input cart_load_pkg::fill_port_t  fill_o,
	input logic                       code_valid_o,
	input cart_load_pkg::sd_req_t     sd_o,
	input logic                       bk_busy_o,
	input logic                       core_reset_o
);

	int fail_count = 0;

	// Expected power-on byte for one address
	function automatic logic [7:0] expected_fill(input logic [1:0] mode, input logic [17:0] a);
		logic [7:0] res;
		res = 8'hFF;
		if (mode == 2'd0) begin
			res = (a[8] != a[2]) ? 8'h66 : 8'h99;
		end else if (mode == 2'd1) begin
			res = (a[9] != a[0]) ? 8'hFF : 8'h00;
		end else if (mode == 2'd2) begin
			res = 8'h55;
		end
		return res;
	endfunction

	fill_data: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_o.we |-> (fill_o.wram_data == expected_fill(wram_mode_i, fill_o.addr))
			&& (fill_o.aram_data == expected_fill(aram_mode_i, fill_o.addr)))
		else begin fail_count++; $error("fill data does not match the mode pattern"); end

	fill_gap: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_o.we |=> !fill_o.we)
		else begin fail_count++; $error("fill writes on two cycles in a row"); end

	// Clear drops one cycle after the last write
	fill_last: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(clearing_o) |-> $past(fill_o.we))
		else begin fail_count++; $error("clear did not end after the last write"); end

	valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid_o |=> !code_valid_o)
		else begin fail_count++; $error("cheat valid longer than one cycle"); end

	sd_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_o.rd && sd_o.wr))
		else begin fail_count++; $error("SD read and write requested together"); end

	sd_drop: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(sd_ack_i) |=> !sd_o.rd && !sd_o.wr)
		else begin fail_count++; $error("SD request still high after ack"); end

	sd_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_o.rd || sd_o.wr) |-> bk_busy_o)
		else begin fail_count++; $error("SD request while backup idle"); end

	clear_reset: assert property (@(posedge clk_sys) disable iff (RESET)
		clearing_o |=> core_reset_o)
		else begin fail_count++; $error("core reset low during the clear"); end

	after_reset: assert property (@(posedge clk_sys)
		$fell(RESET) |-> !clearing_o && !fill_o.we && !code_valid_o
			&& !sd_o.rd && !sd_o.wr && !bk_busy_o)
		else begin fail_count++; $error("outputs active right after reset"); end

endmodule

bind cart_loader_top cart_loader_assertions cart_loader_assertions_i (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.wram_mode_i  (wram_mode_i),
	.aram_mode_i  (aram_mode_i),
	.sd_ack_i     (sd_ack_i),
	.info_o       (info_o),
	.clearing_o   (clearing_o),
	.fill_o       (fill_o),
	.code_valid_o (code_valid_o),
	.sd_o         (sd_o),
	.bk_busy_o    (bk_busy_o),
	.core_reset_o (core_reset_o)
);

// File: tests/tb_cart_loader.sv
// Testbench for the cartridge loader
//   Clock, reset, download stimulus and SD responder
//   Fill, SD and cheat monitors, bounded waits and closing report
module tb_cart_loader;

	logic                       clk_sys;
	logic                       RESET;
	cart_load_pkg::dl_bus_t     dl;
	logic [2:0]                 header_mode;
	logic [1:0]                 region_sel;
	logic [1:0]                 wram_mode;
	logic [1:0]                 aram_mode;
	cart_load_pkg::sd_image_t   img;
	logic                       bk_load;
	logic                       bk_save;
	logic                       sd_ack;
	cart_load_pkg::cart_info_t  info;
	logic                       clearing;
	cart_load_pkg::fill_port_t  fill;
	cart_load_pkg::cheat_code_t code;
	logic                       code_valid;
	cart_load_pkg::sd_req_t     sd;
	logic                       bk_busy;
	logic                       core_reset;

	int          errors = 0;
	int          valid_count = 0;
	int unsigned fill_log[$];
	int unsigned lba_log[$];
	bit          rd_log[$];
	logic [15:0] words[8];
	logic [3:0]  rom_sz;
	logic [3:0]  ram_sz;
	logic [7:0]  rtype;
	logic        region;
	int unsigned last_lba;

	cart_loader_top #(.FILL_ADDR_BITS(6)) cart_loader_top_i (
		.clk_sys (clk_sys), .RESET (RESET), .dl_i (dl),
		.header_mode_i (header_mode), .region_sel_i (region_sel),
		.wram_mode_i (wram_mode), .aram_mode_i (aram_mode), .img_i (img),
		.bk_load_i (bk_load), .bk_save_i (bk_save), .sd_ack_i (sd_ack),
		.info_o (info), .clearing_o (clearing), .fill_o (fill), .code_o (code),
		.code_valid_o (code_valid), .sd_o (sd), .bk_busy_o (bk_busy),
		.core_reset_o (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic dl_write(input logic [24:0] a, input logic [15:0] d);
		@(negedge clk_sys);
		dl.addr = a;
		dl.data = d;
		dl.wr   = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	task automatic dl_open(input logic [7:0] idx);
		@(negedge clk_sys);
		dl.active = 1'b1;
		dl.index  = idx;
	endtask

	task automatic dl_close();
		@(negedge clk_sys);
		dl = '0;
		repeat (3) @(negedge clk_sys);
	endtask

	// Backup load keeps the core in reset until the loader is idle
	task automatic wait_idle(input int limit);
		int  n;
		bit  prev_busy;
		n = 0;
		prev_busy = 1'b0;
		while (clearing || bk_busy) begin
			@(negedge clk_sys);
			if (prev_busy && sd.rd) compare_value("core_reset_o", core_reset, 1);
			prev_busy = bk_busy;
			n++;
			if (n > limit) abort_run("timeout waiting for clear and backup to finish");
		end
		repeat (2) @(negedge clk_sys);
		compare_value("core_reset_o", core_reset, 0);
	endtask

	task automatic check_sectors(input bit is_read, input int unsigned last);
		compare_value("sd request count", lba_log.size(), last + 1);
		foreach (lba_log[i]) begin
			compare_value("sd_o.lba", lba_log[i], i);
			compare_value("sd_o.rd", rd_log[i], is_read);
		end
		lba_log.delete();
		rd_log.delete();
	endtask

	// SD card model, ack a few cycles after each request
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd.rd || sd.wr) && !sd_ack) begin
				lba_log.push_back(sd.lba);
				rd_log.push_back(sd.rd);
				repeat (3) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (2) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk_sys);
			if (fill.we) fill_log.push_back(fill.addr);
			if (code_valid) valid_count++;
		end
	end

	initial begin
		int n;
		void'($urandom(32'h0d38_6687));
		RESET = 1'b1;
		dl = '0;
		header_mode = 3'd2;
		region_sel = 2'd0;
		wram_mode = 2'($urandom % 4);
		aram_mode = 2'($urandom % 4);
		img = '{mounted: 1'b1, readonly: 1'b0, size: 64'd8192};
		bk_load = 1'b0;
		bk_save = 1'b0;
		repeat (8) @(negedge clk_sys);
		RESET = 1'b0;
		repeat (2) @(negedge clk_sys);

		//====================================================================
		// LoROM header, clear and backup load
		//====================================================================
		rom_sz = 4'($urandom % 8);
		ram_sz = 4'(1 + $urandom % 2);
		dl_open(8'h01);
		dl_write(25'd0, 16'($urandom));
		compare_value("core_reset_o", core_reset, 1);
		dl_write(25'h81D6, {4'($urandom), rom_sz, 8'($urandom)});
		dl_write(25'h81D8, {12'($urandom), ram_sz});
		dl_close();
		wait_idle(2000);
		compare_value("fill write count", fill_log.size(), 64);
		foreach (fill_log[i]) compare_value("fill_o.addr", fill_log[i], i);
		compare_value("info_o.rom_type", info.rom_type, 0);
		compare_value("info_o.rom_mask", info.rom_mask, (64'd1024 << rom_sz) - 1);
		compare_value("info_o.ram_mask", info.ram_mask, (64'd1024 << ram_sz) - 1);
		compare_value("info_o.ram_size", info.ram_size, ram_sz);
		last_lba = ((32'd1024 << ram_sz) - 1) >> 9;
		check_sectors(1'b1, last_lba);

		// Save over the same sector range
		@(negedge clk_sys);
		bk_save = 1'b1;
		n = 0;
		while (!bk_busy) begin
			@(negedge clk_sys);
			n++;
			if (n > 20) abort_run("backup save did not start");
		end
		bk_save = 1'b0;
		wait_idle(2000);
		check_sectors(1'b0, last_lba);

		// Manual load with no clear running
		@(negedge clk_sys);
		bk_load = 1'b1;
		n = 0;
		while (!bk_busy) begin
			@(negedge clk_sys);
			n++;
			if (n > 20) abort_run("backup load did not start");
		end
		bk_load = 1'b0;
		wait_idle(2000);
		check_sectors(1'b1, last_lba);

		//====================================================================
		// Auto header mode and region
		//====================================================================
		header_mode = 3'd0;
		rom_sz = 4'($urandom % 8);
		ram_sz = 4'(1 + $urandom % 2);
		rtype = 8'($urandom);
		// First load left the region bit clear
		region = 1'b1;
		fill_log.delete();
		dl_open(8'h01);
		dl_write(25'd0, {rtype, ram_sz, rom_sz});
		dl_write(25'd2, {7'($urandom), region, 8'($urandom)});
		dl_close();
		wait_idle(2000);
		lba_log.delete();
		rd_log.delete();
		compare_value("info_o.rom_type", info.rom_type, rtype);
		compare_value("info_o.rom_mask", info.rom_mask, (64'd1024 << rom_sz) - 1);
		compare_value("info_o.ram_mask", info.ram_mask, (64'd1024 << ram_sz) - 1);
		compare_value("info_o.ram_size", info.ram_size, ram_sz);
		compare_value("info_o.pal", info.pal, region);

		//====================================================================
		// Cheat code
		//====================================================================
		valid_count = 0;
		dl_open(8'hFF);
		foreach (words[i]) begin
			words[i] = 16'($urandom);
			dl_write(25'(2 * i), words[i]);
		end
		n = 0;
		while (valid_count == 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 20) abort_run("cheat code valid never pulsed");
		end
		dl_close();
		compare_value("code_o.flags", code.flags, {words[1], words[0]});
		compare_value("code_o.address", code.address, {words[3], words[2]});
		compare_value("code_o.compare", code.compare, {words[5], words[4]});
		compare_value("code_o.replace", code.replace, {words[7], words[6]});
		compare_value("code_valid_o pulses", valid_count, 1);

		repeat (4) @(negedge clk_sys);
		n = cart_loader_top_i.cart_loader_assertions_i.fail_count;
		$display("Checks done, %0d value errors, %0d assertion failures", errors, n);
		if (errors == 0 && n == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Overall limit on the run
	initial begin
		#5000000;
		abort_run("simulation ran past its time limit");
	end

endmodule

// File: project.f
design/cart_load_pkg.sv
design/download_decoder.sv
design/rom_header_parser.sv
design/mem_clear_engine.sv
design/cheat_code_loader.sv
design/backup_ram_sequencer.sv
design/cart_loader_top.sv
tests/cart_loader_assertions.sv
tests/tb_cart_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_loader -f project.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST PASSED" sim.log; then
	exit 0
fi
exit 1
